// File: bench/reorder_buffer_asserts.sv
`timescale 1ns/1ps

module reorder_buffer_asserts (
  input logic clk,
  input logic rst,
  input logic store_valid,
  input logic store_done,
  input logic reg_commit_valid,
  input logic flush
);

  logic waiting;

  // a store is out and memory has not answered yet
  always_ff @(posedge clk) begin
    if (rst) begin
      waiting <= 1'b0;
    end else if (store_done) begin
      waiting <= 1'b0;
    end else if (store_valid) begin
      waiting <= 1'b1;
    end
  end

  a_one_pulse: assert property (@(posedge clk) disable iff (rst)
    !(store_valid && reg_commit_valid))
    else $error("store and register commit in the same cycle");

  a_flush_len: assert property (@(posedge clk) disable iff (rst) flush |=> !flush)
    else $error("flush longer than one cycle");

  a_store_wait: assert property (@(posedge clk) disable iff (rst)
    waiting |-> !(reg_commit_valid || store_valid || flush))
    else $error("retire while a store is outstanding");

endmodule

bind commit_unit reorder_buffer_asserts reorder_buffer_asserts_i (
  .clk              (clk),
  .rst              (rst),
  .store_valid      (store_valid),
  .store_done       (store_done),
  .reg_commit_valid (reg_commit_valid),
  .flush            (flush)
);

// File: bench/reorder_buffer_tb.sv
`timescale 1ns/1ps

module reorder_buffer_tb;

  import rob_pkg::*;

  localparam int DEPTH = 8;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int RETIRES_PER_TEST = 100;
  // three tests of 100 retirements, at most 40 cycles each, plus reset
  localparam int CYCLE_LIMIT = 300 * 40 + 1000;

  logic clk;
  logic rst;
  logic fetch_req;
  logic fetch_valid;
  logic [31:0] fetch_pc;
  logic [31:0] fetch_instr;
  logic wb_valid;
  logic [PTR_W-1:0] wb_idx;
  logic [31:0] wb_result;
  logic [31:0] wb_tar_addr;
  logic reg_commit_valid;
  logic [4:0] reg_commit_rd;
  logic [31:0] reg_commit_value;
  logic [PTR_W-1:0] reg_commit_tag;
  logic store_valid;
  logic [31:0] store_addr;
  logic [31:0] store_data;
  logic [1:0] store_len;
  logic store_done;
  logic flush;
  logic [31:0] flush_pc;
  logic pc_write_valid;
  logic [31:0] pc_write_value;
  logic [PTR_W-1:0] head;

  // reference model, one slot per buffer index
  logic [6:0] m_opcode [DEPTH];
  logic [4:0] m_rd [DEPTH];
  logic [2:0] m_func3 [DEPTH];
  logic [31:0] m_pc [DEPTH];
  logic [31:0] m_result [DEPTH];
  logic [31:0] m_tar [DEPTH];
  bit m_ready [DEPTH];
  int order [$];
  int m_tail;

  int prev_head;
  bit flush_prev;
  bit fetch_wait;
  int fetch_cnt;
  bit pcw_pending;
  logic [31:0] pcw_expected;
  logic [31:0] next_pc;
  bit store_wait;
  bit done_driven;
  bit mem_busy;
  int mem_cnt;
  int mode;
  int retire_count;
  int errors;
  int cycles;
  bit running;

  reorder_buffer #(.DEPTH(DEPTH)) reorder_buffer_i (.*);

  always #20 clk = ~clk;

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("** Error at %0d ns: %s = %h, expected %h", $time, name, actual, expected);
      errors++;
    end
  endtask

  task automatic report(input string what);
    $display("error at %0d ns: %s", $time, what);
    errors++;
  endtask

  function automatic logic [31:0] decode_imm(input logic [31:0] i);
    case (i[6:0])
      OPC_STORE: return {{20{i[31]}}, i[31:25], i[11:7]};
      OPC_BRANCH: return {{19{i[31]}}, i[31], i[7], i[30:25], i[11:8], 1'b0};
      OPC_JAL: return {{11{i[31]}}, i[31], i[19:12], i[20], i[30:21], 1'b0};
      OPC_LUI: return {i[31:12], 12'b0};
      default: return {{20{i[31]}}, i[31:20]};
    endcase
  endfunction

  // mode 1 alu, mode 2 adds memory ops, mode 3 adds control flow
  function automatic logic [31:0] random_instr(input int m);
    logic [6:0] ops [8];
    logic [31:0] w;
    int n;
    ops = '{OPC_OP, OPC_OP_IMM, OPC_LUI, OPC_LOAD, OPC_STORE, OPC_BRANCH, OPC_JAL, OPC_JALR};
    n = (m == 1) ? 3 : (m == 2) ? 5 : 8;
    w = $urandom();
    w[6:0] = ops[$urandom() % n];
    return w;
  endfunction

  task automatic check_retire();
    int idx;
    logic [6:0] op;
    bit exp_reg;
    bit exp_store;
    bit exp_flush;
    logic [31:0] exp_fpc;
    exp_reg = 0;
    exp_store = 0;
    exp_flush = 0;
    exp_fpc = '0;
    if (flush_prev) begin
      check_value("head", 32'(head), 32'd0);
    end else if (32'(head) != prev_head) begin
      if (store_wait) begin
        report("instruction retired before store_done");
      end
      if (order.size() == 0) begin
        report("head moved with no instruction in the buffer");
      end else begin
        idx = order.pop_front();
        op = m_opcode[idx];
        check_value("head", 32'(head), 32'((idx + 1) % DEPTH));
        case (op)
          OPC_STORE: exp_store = 1;
          OPC_BRANCH: begin
            exp_flush = !m_result[idx][0];
            exp_fpc = m_pc[idx] + 32'd4;
          end
          OPC_JALR: begin
            exp_flush = 1;
            exp_fpc = m_tar[idx];
            exp_reg = m_rd[idx] != 0;
          end
          default: exp_reg = m_rd[idx] != 0;
        endcase
        if (exp_reg && reg_commit_valid) begin
          check_value("reg_commit_rd", 32'(reg_commit_rd), 32'(m_rd[idx]));
          check_value("reg_commit_value", reg_commit_value, m_result[idx]);
          check_value("reg_commit_tag", 32'(reg_commit_tag), 32'(idx));
        end
        if (exp_store && store_valid) begin
          check_value("store_addr", store_addr, m_tar[idx]);
          check_value("store_data", store_data, m_result[idx]);
          check_value("store_len", 32'(store_len),
                      (m_func3[idx][1:0] == 2'd2) ? 32'd3 : 32'(m_func3[idx][1:0]));
          store_wait = 1;
          mem_busy = 1;
          mem_cnt = 1 + $urandom() % 4;
        end
        if (exp_flush && flush) begin
          check_value("flush_pc", flush_pc, exp_fpc);
          next_pc = exp_fpc;
        end
        retire_count++;
      end
    end
    check_value("reg_commit_valid", 32'(reg_commit_valid), 32'(exp_reg));
    check_value("store_valid", 32'(store_valid), 32'(exp_store));
    check_value("flush", 32'(flush), 32'(exp_flush));
    prev_head = 32'(head);
  endtask

  task automatic observe_outputs();
    if (fetch_req) begin
      if (order.size() + 1 >= DEPTH) begin
        report("fetch_req raised with the buffer full");
      end
      if (fetch_wait) begin
        report("fetch_req raised while a fetch is outstanding");
      end
    end
    check_retire();
    if (pcw_pending) begin
      check_value("pc_write_valid", 32'(pc_write_valid), 32'd1);
      check_value("pc_write_value", pc_write_value, pcw_expected);
      pcw_pending = 0;
    end else begin
      check_value("pc_write_valid", 32'(pc_write_valid), 32'd0);
    end
    if (flush) begin
      order.delete();
      m_tail = 0;
      fetch_wait = 0;
    end else if (fetch_req) begin
      fetch_wait = 1;
      fetch_cnt = 1 + $urandom() % 3;
    end
    if (done_driven) begin
      store_wait = 0;
      done_driven = 0;
    end
    flush_prev = flush;
  endtask

  task automatic drive_inputs();
    int cand [$];
    int pick;
    logic [31:0] instr;
    logic [31:0] imm;
    fetch_valid = 0;
    wb_valid = 0;
    store_done = 0;
    if (mem_busy) begin
      mem_cnt--;
      if (mem_cnt == 0) begin
        store_done = 1;
        mem_busy = 0;
        done_driven = 1;
      end
    end
    if (!flush) begin
      foreach (order[k]) begin
        if (!m_ready[order[k]]) cand.push_back(order[k]);
      end
      if (cand.size() > 0 && $urandom() % 2 == 1) begin
        pick = cand[$urandom() % cand.size()];
        wb_valid = 1;
        wb_idx = PTR_W'(pick);
        wb_result = $urandom();
        wb_tar_addr = $urandom();
        m_ready[pick] = 1;
        m_result[pick] = wb_result;
        m_tar[pick] = wb_tar_addr;
      end
      if (fetch_wait) begin
        fetch_cnt--;
        if (fetch_cnt == 0) begin
          instr = random_instr(mode);
          imm = decode_imm(instr);
          fetch_valid = 1;
          fetch_pc = next_pc;
          fetch_instr = instr;
          m_opcode[m_tail] = instr[6:0];
          m_rd[m_tail] = (instr[6:0] == OPC_STORE || instr[6:0] == OPC_BRANCH) ? 5'd0
                                                                              : instr[11:7];
          m_func3[m_tail] = instr[14:12];
          m_pc[m_tail] = next_pc;
          m_ready[m_tail] = 0;
          order.push_back(m_tail);
          m_tail = (m_tail + 1) % DEPTH;
          pcw_pending = 1;
          if (instr[6:0] == OPC_JAL || instr[6:0] == OPC_BRANCH) begin
            pcw_expected = next_pc + imm;
          end else begin
            pcw_expected = next_pc + 32'd4;
          end
          next_pc = pcw_expected;
          fetch_wait = 0;
        end
      end
    end
  endtask

  always @(negedge clk) begin
    if (running) begin
      cycles++;
      observe_outputs();
      drive_inputs();
      if (cycles >= CYCLE_LIMIT) begin
        $display("timeout after %0d cycles with %0d retirements", cycles, retire_count);
        $display("sim failed");
        $finish;
      end
    end
  end

  initial begin
    string names [3];
    int start_errors;
    int target;
    names = '{"alu only", "with stores", "full mix"};
    clk = 0;
    rst = 1;
    fetch_valid = 0;
    fetch_pc = '0;
    fetch_instr = '0;
    wb_valid = 0;
    wb_idx = '0;
    wb_result = '0;
    wb_tar_addr = '0;
    store_done = 0;
    next_pc = 32'h0000_1000;
    mode = 1;
    void'($urandom(96));
    repeat (16) @(posedge clk);
    running = 1;
    @(negedge clk);
    rst = 0;
    for (int t = 1; t <= 3; t++) begin
      mode = t;
      start_errors = errors;
      target = retire_count + RETIRES_PER_TEST;
      while (retire_count < target) @(posedge clk);
      $display("test %0d %s: %0d retirements, %0d errors", t, names[t-1],
               RETIRES_PER_TEST, errors - start_errors);
    end
    running = 0;
    $display("tests 3, retirements %0d, errors %0d", retire_count, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// File: logic/commit_unit.sv
`timescale 1ns/1ps

module commit_unit #(
  parameter int DEPTH = 8,
  localparam int PTR_W = $clog2(DEPTH)
) (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             store_done,
  input  logic [PTR_W-1:0]                 tail,
  input  logic                             ent_ready [DEPTH],
  input  logic [rob_pkg::OPCODE_W-1:0]     ent_opcode [DEPTH],
  input  logic [rob_pkg::REG_ADDR_W-1:0]   ent_rd [DEPTH],
  input  logic [rob_pkg::FUNC3_W-1:0]      ent_func3 [DEPTH],
  input  logic [rob_pkg::XLEN-1:0]         ent_imm [DEPTH],
  input  logic [rob_pkg::XLEN-1:0]         ent_pc [DEPTH],
  input  logic [rob_pkg::XLEN-1:0]         ent_result [DEPTH],
  input  logic [rob_pkg::XLEN-1:0]         ent_tar_addr [DEPTH],
  output logic [PTR_W-1:0]                 head,
  output logic                             reg_commit_valid,
  output logic [rob_pkg::REG_ADDR_W-1:0]   reg_commit_rd,
  output logic [rob_pkg::XLEN-1:0]         reg_commit_value,
  output logic [PTR_W-1:0]                 reg_commit_tag,
  output logic                             store_valid,
  output logic [rob_pkg::XLEN-1:0]         store_addr,
  output logic [rob_pkg::XLEN-1:0]         store_data,
  output logic [1:0]                       store_len,
  output logic                             flush,
  output logic [rob_pkg::XLEN-1:0]         flush_pc
);

  import rob_pkg::*;

  localparam logic PREDICT_TAKEN = 1'b1;

  logic store_pending;
  logic retire;
  logic [OPCODE_W-1:0] head_opcode;
  logic [REG_ADDR_W-1:0] head_rd;
  logic [FUNC3_W-1:0] head_func3;
  logic [XLEN-1:0] head_pc;
  logic [XLEN-1:0] head_result;
  logic taken;
  logic mispredict;
  logic [1:0] head_len;

  assign head_opcode = ent_opcode[head];
  assign head_rd = ent_rd[head];
  assign head_func3 = ent_func3[head];
  assign head_pc = ent_pc[head];
  assign head_result = ent_result[head];

  assign taken = head_result[0];
  assign mispredict = taken != PREDICT_TAKEN;
  // byte, half, word as 0, 1, 3
  assign head_len = (head_func3[1:0] == 2'd2) ? 2'd3 : head_func3[1:0];

  assign retire = (head != tail) && ent_ready[head] && !store_pending && !flush;

  always_ff @(posedge clk) begin
    if (rst) begin
      head <= '0;
      store_pending <= 1'b0;
      reg_commit_valid <= 1'b0;
      store_valid <= 1'b0;
      flush <= 1'b0;
    end else begin
      reg_commit_valid <= 1'b0;
      store_valid <= 1'b0;
      flush <= 1'b0;
      if (store_pending && store_done) begin
        store_pending <= 1'b0;
      end
      if (flush) begin
        head <= '0;
      end else if (retire) begin
        head <= head + 1'b1;
        case (head_opcode)
          OPC_STORE: begin
            store_valid <= 1'b1;
            store_pending <= 1'b1;
          end
          OPC_BRANCH: begin
            flush <= mispredict;
          end
          OPC_JALR: begin
            // link write goes out with the flush
            flush <= 1'b1;
            reg_commit_valid <= head_rd != '0;
          end
          default: begin
            reg_commit_valid <= head_rd != '0;
          end
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (retire) begin
      reg_commit_rd <= head_rd;
      reg_commit_value <= head_result;
      reg_commit_tag <= head;
      store_addr <= ent_tar_addr[head];
      store_data <= head_result;
      store_len <= head_len;
      if (head_opcode == OPC_JALR) begin
        flush_pc <= ent_tar_addr[head];
      end else begin
        flush_pc <= taken ? head_pc + ent_imm[head] : head_pc + 32'd4;
      end
    end
  end

endmodule

// File: logic/fetch_sequencer.sv
`timescale 1ns/1ps

module fetch_sequencer #(
  parameter int DEPTH = 8,
  localparam int PTR_W = $clog2(DEPTH)
) (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             fetch_valid,
  input  logic [rob_pkg::XLEN-1:0]         fetch_pc,
  input  logic [rob_pkg::XLEN-1:0]         fetch_instr,
  input  logic [PTR_W-1:0]                 head,
  input  logic                             flush,
  output logic                             fetch_req,
  output logic                             alloc_en,
  output logic [PTR_W-1:0]                 alloc_idx,
  output logic [rob_pkg::OPCODE_W-1:0]     alloc_opcode,
  output logic [rob_pkg::REG_ADDR_W-1:0]   alloc_rd,
  output logic [rob_pkg::FUNC3_W-1:0]      alloc_func3,
  output logic [rob_pkg::XLEN-1:0]         alloc_imm,
  output logic [rob_pkg::XLEN-1:0]         alloc_pc,
  output logic                             pc_write_valid,
  output logic [rob_pkg::XLEN-1:0]         pc_write_value
);

  import rob_pkg::*;

  logic fetching;
  logic [PTR_W-1:0] tail;
  logic [PTR_W-1:0] occupancy;
  logic has_room;
  rv_instr_u instr;
  logic [OPCODE_W-1:0] opcode;
  logic [XLEN-1:0] imm;
  logic [XLEN-1:0] next_pc;

  assign occupancy = tail - head;
  // keep one slot free, as head == tail means empty
  assign has_room = ({1'b0, occupancy} + 1'b1) < (PTR_W + 1)'(DEPTH);

  assign instr = fetch_instr;
  assign opcode = instr.i_view.opcode;

  // immediate by format
  always_comb begin
    case (opcode)
      OPC_STORE: begin
        imm = {{20{instr.s_view.imm_11_5[6]}}, instr.s_view.imm_11_5, instr.s_view.imm_4_0};
      end
      OPC_BRANCH: begin
        imm = {{19{instr.b_view.imm_12}}, instr.b_view.imm_12, instr.b_view.imm_11,
               instr.b_view.imm_10_5, instr.b_view.imm_4_1, 1'b0};
      end
      OPC_JAL: begin
        imm = {{11{instr.j_view.imm_20}}, instr.j_view.imm_20, instr.j_view.imm_19_12,
               instr.j_view.imm_11, instr.j_view.imm_10_1, 1'b0};
      end
      OPC_LUI: begin
        imm = {fetch_instr[31:12], 12'b0};
      end
      default: begin
        imm = {{20{instr.i_view.imm_11_0[11]}}, instr.i_view.imm_11_0};
      end
    endcase
  end

  // branches are always predicted taken
  always_comb begin
    if (opcode == OPC_JAL || opcode == OPC_BRANCH) begin
      next_pc = fetch_pc + imm;
    end else begin
      next_pc = fetch_pc + 32'd4;
    end
  end

  assign alloc_en = fetching && fetch_valid && !flush;
  assign alloc_idx = tail;
  assign alloc_opcode = opcode;
  assign alloc_func3 = instr.i_view.func3;
  assign alloc_imm = imm;
  assign alloc_pc = fetch_pc;
  // stores and branches write no register
  assign alloc_rd = (opcode == OPC_STORE || opcode == OPC_BRANCH) ? '0 : instr.i_view.rd;

  always_ff @(posedge clk) begin
    if (rst) begin
      fetching <= 1'b0;
      tail <= '0;
      fetch_req <= 1'b0;
      pc_write_valid <= 1'b0;
    end else begin
      fetch_req <= 1'b0;
      pc_write_valid <= 1'b0;
      if (flush) begin
        fetching <= 1'b0;
        tail <= '0;
      end else if (!fetching) begin
        if (has_room) begin
          fetch_req <= 1'b1;
          fetching <= 1'b1;
        end
      end else if (fetch_valid) begin
        tail <= tail + 1'b1;
        pc_write_valid <= 1'b1;
        fetching <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (alloc_en) begin
      pc_write_value <= next_pc;
    end
  end

endmodule

// File: logic/reorder_buffer.sv
`timescale 1ns/1ps

module reorder_buffer #(
  parameter int DEPTH = 8,
  localparam int PTR_W = $clog2(DEPTH)
) (
  input  logic                             clk,
  input  logic                             rst,
  output logic                             fetch_req,
  input  logic                             fetch_valid,
  input  logic [rob_pkg::XLEN-1:0]         fetch_pc,
  input  logic [rob_pkg::XLEN-1:0]         fetch_instr,
  input  logic                             wb_valid,
  input  logic [PTR_W-1:0]                 wb_idx,
  input  logic [rob_pkg::XLEN-1:0]         wb_result,
  input  logic [rob_pkg::XLEN-1:0]         wb_tar_addr,
  output logic                             reg_commit_valid,
  output logic [rob_pkg::REG_ADDR_W-1:0]   reg_commit_rd,
  output logic [rob_pkg::XLEN-1:0]         reg_commit_value,
  output logic [PTR_W-1:0]                 reg_commit_tag,
  output logic                             store_valid,
  output logic [rob_pkg::XLEN-1:0]         store_addr,
  output logic [rob_pkg::XLEN-1:0]         store_data,
  output logic [1:0]                       store_len,
  input  logic                             store_done,
  output logic                             flush,
  output logic [rob_pkg::XLEN-1:0]         flush_pc,
  output logic                             pc_write_valid,
  output logic [rob_pkg::XLEN-1:0]         pc_write_value,
  output logic [PTR_W-1:0]                 head
);

  import rob_pkg::*;

  logic alloc_en;
  logic [PTR_W-1:0] alloc_idx;
  logic [OPCODE_W-1:0] alloc_opcode;
  logic [REG_ADDR_W-1:0] alloc_rd;
  logic [FUNC3_W-1:0] alloc_func3;
  logic [XLEN-1:0] alloc_imm;
  logic [XLEN-1:0] alloc_pc;

  logic ent_ready [DEPTH];
  logic [OPCODE_W-1:0] ent_opcode [DEPTH];
  logic [REG_ADDR_W-1:0] ent_rd [DEPTH];
  logic [FUNC3_W-1:0] ent_func3 [DEPTH];
  logic [XLEN-1:0] ent_imm [DEPTH];
  logic [XLEN-1:0] ent_pc [DEPTH];
  logic [XLEN-1:0] ent_result [DEPTH];
  logic [XLEN-1:0] ent_tar_addr [DEPTH];

  fetch_sequencer #(.DEPTH(DEPTH)) fetch_sequencer_i (
    .clk            (clk),
    .rst            (rst),
    .fetch_valid    (fetch_valid),
    .fetch_pc       (fetch_pc),
    .fetch_instr    (fetch_instr),
    .head           (head),
    .flush          (flush),
    .fetch_req      (fetch_req),
    .alloc_en       (alloc_en),
    .alloc_idx      (alloc_idx),
    .alloc_opcode   (alloc_opcode),
    .alloc_rd       (alloc_rd),
    .alloc_func3    (alloc_func3),
    .alloc_imm      (alloc_imm),
    .alloc_pc       (alloc_pc),
    .pc_write_valid (pc_write_valid),
    .pc_write_value (pc_write_value)
  );

  for (genvar i = 0; i < DEPTH; i++) begin : g_entry
    rob_entry #(.IDX(i), .DEPTH(DEPTH)) rob_entry_i (
      .clk          (clk),
      .alloc_en     (alloc_en),
      .alloc_idx    (alloc_idx),
      .alloc_opcode (alloc_opcode),
      .alloc_rd     (alloc_rd),
      .alloc_func3  (alloc_func3),
      .alloc_imm    (alloc_imm),
      .alloc_pc     (alloc_pc),
      .wb_valid     (wb_valid),
      .wb_idx       (wb_idx),
      .wb_result    (wb_result),
      .wb_tar_addr  (wb_tar_addr),
      .ready        (ent_ready[i]),
      .opcode       (ent_opcode[i]),
      .rd           (ent_rd[i]),
      .func3        (ent_func3[i]),
      .imm          (ent_imm[i]),
      .pc           (ent_pc[i]),
      .result       (ent_result[i]),
      .tar_addr     (ent_tar_addr[i])
    );
  end

  // alloc_idx is the tail pointer
  commit_unit #(.DEPTH(DEPTH)) commit_unit_i (
    .clk              (clk),
    .rst              (rst),
    .store_done       (store_done),
    .tail             (alloc_idx),
    .ent_ready        (ent_ready),
    .ent_opcode       (ent_opcode),
    .ent_rd           (ent_rd),
    .ent_func3        (ent_func3),
    .ent_imm          (ent_imm),
    .ent_pc           (ent_pc),
    .ent_result       (ent_result),
    .ent_tar_addr     (ent_tar_addr),
    .head             (head),
    .reg_commit_valid (reg_commit_valid),
    .reg_commit_rd    (reg_commit_rd),
    .reg_commit_value (reg_commit_value),
    .reg_commit_tag   (reg_commit_tag),
    .store_valid      (store_valid),
    .store_addr       (store_addr),
    .store_data       (store_data),
    .store_len        (store_len),
    .flush            (flush),
    .flush_pc         (flush_pc)
  );

endmodule

// File: logic/rob_entry.sv
`timescale 1ns/1ps

module rob_entry #(
  parameter int IDX = 0,
  parameter int DEPTH = 8,
  localparam int PTR_W = $clog2(DEPTH)
) (
  input  logic                             clk,
  input  logic                             alloc_en,
  input  logic [PTR_W-1:0]                 alloc_idx,
  input  logic [rob_pkg::OPCODE_W-1:0]     alloc_opcode,
  input  logic [rob_pkg::REG_ADDR_W-1:0]   alloc_rd,
  input  logic [rob_pkg::FUNC3_W-1:0]      alloc_func3,
  input  logic [rob_pkg::XLEN-1:0]         alloc_imm,
  input  logic [rob_pkg::XLEN-1:0]         alloc_pc,
  input  logic                             wb_valid,
  input  logic [PTR_W-1:0]                 wb_idx,
  input  logic [rob_pkg::XLEN-1:0]         wb_result,
  input  logic [rob_pkg::XLEN-1:0]         wb_tar_addr,
  output logic                             ready,
  output logic [rob_pkg::OPCODE_W-1:0]     opcode,
  output logic [rob_pkg::REG_ADDR_W-1:0]   rd,
  output logic [rob_pkg::FUNC3_W-1:0]      func3,
  output logic [rob_pkg::XLEN-1:0]         imm,
  output logic [rob_pkg::XLEN-1:0]         pc,
  output logic [rob_pkg::XLEN-1:0]         result,
  output logic [rob_pkg::XLEN-1:0]         tar_addr
);

  logic alloc_hit;
  logic wb_hit;

  assign alloc_hit = alloc_en && (alloc_idx == PTR_W'(IDX));
  assign wb_hit = wb_valid && (wb_idx == PTR_W'(IDX));

  // fields captured at allocation
  always_ff @(posedge clk) begin
    if (alloc_hit) begin
      opcode <= alloc_opcode;
      rd <= alloc_rd;
      func3 <= alloc_func3;
      imm <= alloc_imm;
      pc <= alloc_pc;
    end
  end

  // ready drops on allocation, rises on writeback
  always_ff @(posedge clk) begin
    if (alloc_hit) begin
      ready <= 1'b0;
    end
    if (wb_hit) begin
      ready <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (wb_hit) begin
      result <= wb_result;
      tar_addr <= wb_tar_addr;
    end
  end

endmodule

// File: logic/rob_pkg.sv
package rob_pkg;

  parameter int XLEN = 32;
  parameter int REG_ADDR_W = 5;
  parameter int OPCODE_W = 7;
  parameter int FUNC3_W = 3;

  // rv32i major opcodes
  parameter logic [OPCODE_W-1:0] OPC_LOAD = 7'b0000011;
  parameter logic [OPCODE_W-1:0] OPC_STORE = 7'b0100011;
  parameter logic [OPCODE_W-1:0] OPC_BRANCH = 7'b1100011;
  parameter logic [OPCODE_W-1:0] OPC_JAL = 7'b1101111;
  parameter logic [OPCODE_W-1:0] OPC_JALR = 7'b1100111;
  parameter logic [OPCODE_W-1:0] OPC_OP = 7'b0110011;
  parameter logic [OPCODE_W-1:0] OPC_OP_IMM = 7'b0010011;
  parameter logic [OPCODE_W-1:0] OPC_LUI = 7'b0110111;

  // one instruction word, read through the immediate layout of its format
  typedef union packed {
    struct packed {
      logic [11:0] imm_11_0;
      logic [REG_ADDR_W-1:0] rs1;
      logic [FUNC3_W-1:0] func3;
      logic [REG_ADDR_W-1:0] rd;
      logic [OPCODE_W-1:0] opcode;
    } i_view;
    struct packed {
      logic [6:0] imm_11_5;
      logic [REG_ADDR_W-1:0] rs2;
      logic [REG_ADDR_W-1:0] rs1;
      logic [FUNC3_W-1:0] func3;
      logic [4:0] imm_4_0;
      logic [OPCODE_W-1:0] opcode;
    } s_view;
    struct packed {
      logic imm_12;
      logic [5:0] imm_10_5;
      logic [REG_ADDR_W-1:0] rs2;
      logic [REG_ADDR_W-1:0] rs1;
      logic [FUNC3_W-1:0] func3;
      logic [3:0] imm_4_1;
      logic imm_11;
      logic [OPCODE_W-1:0] opcode;
    } b_view;
    struct packed {
      logic imm_20;
      logic [9:0] imm_10_1;
      logic imm_11;
      logic [7:0] imm_19_12;
      logic [REG_ADDR_W-1:0] rd;
      logic [OPCODE_W-1:0] opcode;
    } j_view;
  } rv_instr_u;

endpackage

// File: run_sim.sh
#!/bin/bash
# build and run the reorder buffer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f \
  --top-module reorder_buffer_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/Vreorder_buffer_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^sim passed$" sim.log; then
  exit 0
fi
exit 1

// File: verilog.f
logic/rob_pkg.sv
logic/fetch_sequencer.sv
logic/rob_entry.sv
logic/commit_unit.sv
logic/reorder_buffer.sv
bench/reorder_buffer_asserts.sv
bench/reorder_buffer_tb.sv
